// File: adc_test_patterns.txt
# op  cache_cmd  cache_stat  read_mode  (op: I init, T type, C conf, V convert)
# read_mode for V: 0 random reads, 1 read every cycle, 2 no reads until fd_conv is due
I 00000000 00000010 0
T 00000000 0000FF30 0
C 000F0000 73F4FF70 0
V 000F0000 73F4FFF0 0
V 000F0000 73F4FFF0 1
C 00311000 73F4FFF0 0
V 00311000 73F4FFF0 1
C 00200000 73F4FFF0 0
V 00200000 73F4FFF0 2
V 00200000 73F4FFF0 0

// File: compile.f
adc_pkg.sv
adc_ctrl.sv
adc_pattern_gen.sv
adc_chan_fifo.sv
adc_status_reg.sv
adc_test_top.sv
tb_adc_test.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_adc_test
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_adc_test.sv
`timescale 1ns/1ps

module tb_adc_test
    import adc_pkg::*;
();

    logic        clk;
    logic        rst;
    logic [3:0]  fs_req;                      // init, type, conf, conv
    logic [3:0]  fd_all;
    logic        fd_init;
    logic        fd_type;
    logic        fd_conf;
    logic        fd_conv;
    adc_cmd_t    cache_cmd;
    adc_stat_t   cache_stat;
    logic [7:0]  fifo_rxen;
    logic [63:0] fifo_rxd;
    logic [7:0]  fifo_rxv;

    logic [7:0]  pat_op[$];
    logic [31:0] pat_cmd[$];
    logic [31:0] pat_stat[$];
    int          pat_mode[$];

    string       cmd_name[4] = '{"init", "type", "conf", "conv"};
    int          err_cnt;
    int          tests_run;
    int          tests_bad;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state;
    logic [3:0]  cfg_freq;                    // From the last C line
    logic [3:0]  cfg_up;
    logic [3:0]  cfg_low;
    int          got[NUM_CH];
    int          pace_freq;
    int          pace_lat;

    adc_test_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .fs_init    (fs_req[0]),
        .fs_type    (fs_req[1]),
        .fs_conf    (fs_req[2]),
        .fs_conv    (fs_req[3]),
        .fd_init    (fd_init),
        .fd_type    (fd_type),
        .fd_conf    (fd_conf),
        .fd_conv    (fd_conv),
        .cache_cmd  (cache_cmd),
        .cache_stat (cache_stat),
        .fifo_rxen  (fifo_rxen),
        .fifo_rxd   (fifo_rxd),
        .fifo_rxv   (fifo_rxv)
    );

    assign fd_all = {fd_conv, fd_conf, fd_type, fd_init};

    always #4 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_limit > 0);
        wait (cycle_cnt > cycle_limit);
        $display("Timeout after %0d cycles, a DUT handshake never completed", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    // ########################################
    // Helpers
    // ########################################

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Ramp start 01, 03 .. 0F, then clipped to the filter window
    function automatic sample_t expect_sample(input int ch, input int n);
        int raw;
        int lo;
        int hi;
        raw = 2 * ch + 1 + n;
        lo  = 16 * int'(cfg_low);
        hi  = 16 * int'(cfg_up) + 15;
        if (raw < lo) raw = lo;
        else if (raw > hi) raw = hi;
        return sample_t'(raw);
    endfunction

    function automatic bit all_drained();
        for (int k = 0; k < NUM_CH; k++) begin
            if (got[k] < NUM_SAMPLES) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_patterns();
        int               fd;
        int               rc;
        logic [7:0]       op;
        logic [31:0]      cmd;
        logic [31:0]      stat;
        int               mode;
        logic [8*160-1:0] rest;
        fd = $fopen("adc_test_patterns.txt", "r");
        if (fd == 0) return;
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                rc = $fgets(rest, fd);        // Rest of a comment line
            end else begin
                rc = $fscanf(fd, " %h %h %d", cmd, stat, mode);
                if (rc == 3) begin
                    pat_op.push_back(op);
                    pat_cmd.push_back(cmd);
                    pat_stat.push_back(stat);
                    pat_mode.push_back(mode);
                end
            end
        end
        $fclose(fd);
    endtask

    // ########################################
    // Command handshake
    // ########################################

    task automatic release_cmd(input int idx);
        int n;
        n = 0;
        fs_req[idx] = 1'b0;
        while (fd_all[idx]) begin
            next_cycle();
            n++;
        end
        assert (n <= 2) else begin
            $display("fd_%s took %0d cycles to fall after fs dropped", cmd_name[idx], n);
            err_cnt++;
        end
        next_cycle();                         // Controller back in WAIT
    endtask

    task automatic run_fixed(input int idx, input int exp_lat);
        int lat;
        lat = 0;
        fs_req[idx] = 1'b1;
        next_cycle();                         // Edge that samples fs in WAIT
        while (!fd_all[idx]) begin
            next_cycle();
            lat++;
        end
        assert (lat == exp_lat) else begin
            $display("ERR t=%0t fd_%s latency got %0d exp %0d",
                     $time, cmd_name[idx], lat, exp_lat);
            err_cnt++;
        end
        repeat (3) begin
            next_cycle();
            assert (fd_all[idx]) else begin
                $display("fd_%s fell while fs was still held", cmd_name[idx]);
                err_cnt++;
            end
        end
        release_cmd(idx);
    endtask

    // ########################################
    // Convert and FIFO reads
    // ########################################

    // Reads decided now take effect on the next edge
    task automatic take_reads();
        sample_t d;
        sample_t e;
        for (int k = 0; k < NUM_CH; k++) begin
            if (fifo_rxen[k] && fifo_rxv[k]) begin
                d = fifo_rxd[k*SAMPLE_W +: SAMPLE_W];
                assert (got[k] < NUM_SAMPLES) else begin
                    $display("Channel %0d delivered more than %0d samples", k, NUM_SAMPLES);
                    err_cnt++;
                end
                if (got[k] < NUM_SAMPLES) begin
                    e = expect_sample(k, got[k]);
                    assert (d == e) else begin
                        $display("ERR t=%0t fifo_rxd[ch%0d] sample %0d got %02h exp %02h",
                                 $time, k, got[k], d, e);
                        err_cnt++;
                    end
                end
                got[k]++;
            end
        end
    endtask

    task automatic run_convert(input int mode);
        int lat;
        int hold;
        int drain;
        int bound;
        lat   = 0;
        drain = 0;
        hold  = NUM_SAMPLES * (int'(cfg_freq) + 1) + 8;
        bound = NUM_SAMPLES * (int'(cfg_freq) + 1);
        for (int k = 0; k < NUM_CH; k++) got[k] = 0;
        fs_req[3] = 1'b1;
        next_cycle();
        while (!fd_conv) begin
            case (mode)
                0: begin
                    lcg_state = lcg_next(lcg_state);
                    fifo_rxen = lcg_state[23:16];  // About half the cycles
                end
                1: fifo_rxen = 8'hFF;
                default: fifo_rxen = (lat < hold) ? 8'h00 : 8'hFF;
            endcase
            if (mode == 2 && lat == hold) begin
                assert (fifo_rxv == 8'hFF) else begin
                    $display("ERR t=%0t fifo_rxv got %02h exp ff", $time, fifo_rxv);
                    err_cnt++;
                end
            end
            take_reads();
            next_cycle();
            lat++;
        end
        if (mode == 2) begin
            assert (lat > hold) else begin
                $display("fd_conv rose after %0d cycles while samples were still unread", lat);
                err_cnt++;
            end
        end
        if (mode == 1) begin
            assert (lat >= bound) else begin
                $display("ERR t=%0t fd_conv latency got %0d exp at least %0d",
                         $time, lat, bound);
                err_cnt++;
            end
            if (pace_lat >= 0 && int'(cfg_freq) > pace_freq) begin
                assert (lat > pace_lat) else begin
                    $display("Slower sample rate did not lengthen the convert (%0d vs %0d)",
                             lat, pace_lat);
                    err_cnt++;
                end
            end
            pace_freq = int'(cfg_freq);
            pace_lat  = lat;
        end
        fifo_rxen = 8'hFF;                    // Drain with fs still held
        while (!all_drained() && drain < 2 * FIFO_DEPTH + 4) begin
            take_reads();
            next_cycle();
            drain++;
        end
        fifo_rxen = 8'h00;
        release_cmd(3);
        for (int k = 0; k < NUM_CH; k++) begin
            assert (got[k] == NUM_SAMPLES) else begin
                $display("ERR t=%0t sample count ch%0d got %0d exp %0d",
                         $time, k, got[k], NUM_SAMPLES);
                err_cnt++;
            end
        end
        assert (fifo_rxv == 8'h00) else begin
            $display("ERR t=%0t fifo_rxv got %02h exp 00", $time, fifo_rxv);
            err_cnt++;
        end
    endtask

    // ########################################
    // Sequence
    // ########################################

    task automatic check_reset();
        int errs;
        errs = err_cnt;
        assert (fd_all == 4'b0000) else begin
            $display("ERR t=%0t fd_all got %b exp 0000", $time, fd_all);
            err_cnt++;
        end
        assert (fifo_rxv == 8'h00) else begin
            $display("ERR t=%0t fifo_rxv got %02h exp 00", $time, fifo_rxv);
            err_cnt++;
        end
        assert (cache_stat == 32'h0) else begin
            $display("ERR t=%0t cache_stat got %08h exp 00000000", $time, cache_stat);
            err_cnt++;
        end
        tests_run++;
        if (err_cnt != errs) tests_bad++;
        $display("Test 0 reset: %s", (err_cnt == errs) ? "ok" : "fail");
    endtask

    task automatic run_pattern(input int i);
        int errs;
        errs = err_cnt;
        cache_cmd = adc_cmd_t'(pat_cmd[i]);   // No command active here
        case (pat_op[i])
            "I": run_fixed(0, NUM_INIT + 2);
            "T": run_fixed(1, NUM_TYPE + 2);
            "C": begin
                run_fixed(2, NUM_CONF + 2);
                cfg_freq = cache_cmd.freq_samp;
                cfg_up   = cache_cmd.filt_up;
                cfg_low  = cache_cmd.filt_low;
            end
            "V": run_convert(pat_mode[i]);
            default: begin
                $display("Unknown command letter on pattern %0d", i + 1);
                err_cnt++;
            end
        endcase
        assert (cache_stat == pat_stat[i]) else begin
            $display("ERR t=%0t cache_stat got %08h exp %08h", $time, cache_stat, pat_stat[i]);
            err_cnt++;
        end
        tests_run++;
        if (err_cnt != errs) tests_bad++;
        $display("Test %0d %c mode %0d: %s", i + 1, pat_op[i], pat_mode[i],
                 (err_cnt == errs) ? "ok" : "fail");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        fs_req    = 4'b0000;
        cache_cmd = '0;
        fifo_rxen = 8'h00;
        err_cnt   = 0;
        tests_run = 0;
        tests_bad = 0;
        lcg_state = 32'h48ba;
        cfg_freq  = 4'h0;
        cfg_up    = 4'h0;
        cfg_low   = 4'h0;
        pace_freq = 0;
        pace_lat  = -1;
        load_patterns();
        if (pat_op.size() == 0) begin
            $display("Pattern file adc_test_patterns.txt missing or empty");
            $display("TB FAILED");
            $finish;
        end else begin
            cycle_limit = pat_op.size() * (NUM_CONF + 4 + NUM_SAMPLES * 16 * 4) * 2;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            check_reset();
            next_cycle();                     // IDLE to WAIT
            foreach (pat_op[i]) run_pattern(i);
            $display("Summary: %0d tests, %0d failed, %0d errors",
                     tests_run, tests_bad, err_cnt);
            if (err_cnt == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// File: adc_test_top.sv
`timescale 1ns/1ps

module adc_test_top
    import adc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fs_init,
    input  logic        fs_type,
    input  logic        fs_conf,
    input  logic        fs_conv,
    output logic        fd_init,
    output logic        fd_type,
    output logic        fd_conf,
    output logic        fd_conv,
    input  adc_cmd_t    cache_cmd,
    output adc_stat_t   cache_stat,
    input  logic [7:0]  fifo_rxen,
    output logic [63:0] fifo_rxd,
    output logic [7:0]  fifo_rxv
);

    logic                 type_load;
    logic                 conf_load;
    logic [3:0]           done_mark;
    logic                 conv_run;
    logic                 conv_end;
    adc_cfg_t             cfg;
    sample_t [NUM_CH-1:0] wr_data;
    logic [NUM_CH-1:0]    wr_en;
    logic [NUM_CH-1:0]    full;

    adc_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .fs_init   (fs_init),
        .fs_type   (fs_type),
        .fs_conf   (fs_conf),
        .fs_conv   (fs_conv),
        .fd_init   (fd_init),
        .fd_type   (fd_type),
        .fd_conf   (fd_conf),
        .fd_conv   (fd_conv),
        .conv_end  (conv_end),
        .conv_run  (conv_run),
        .type_load (type_load),
        .conf_load (conf_load),
        .done_mark (done_mark)
    );

    adc_status_reg i_stat (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cache_cmd),
        .type_load (type_load),
        .conf_load (conf_load),
        .done_mark (done_mark),
        .cfg       (cfg),
        .stat      (cache_stat)
    );

    adc_pattern_gen i_gen (
        .clk      (clk),
        .rst      (rst),
        .conv_run (conv_run),
        .cfg      (cfg),
        .full     (full),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .conv_end (conv_end)
    );

    // Channel k on byte k of the read bus
    for (genvar k = 0; k < NUM_CH; k++) begin : g_fifo
        adc_chan_fifo i_fifo (
            .clk   (clk),
            .rst   (rst),
            .wr_en (wr_en[k]),
            .din   (wr_data[k]),
            .full  (full[k]),
            .rd_en (fifo_rxen[k]),
            .dout  (fifo_rxd[k*SAMPLE_W +: SAMPLE_W]),
            .valid (fifo_rxv[k])
        );
    end

endmodule

// File: adc_status_reg.sv
`timescale 1ns/1ps

module adc_status_reg
    import adc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  adc_cmd_t   cmd,
    input  logic       type_load,
    input  logic       conf_load,
    input  logic [3:0] done_mark,
    output adc_cfg_t   cfg,
    output adc_stat_t  stat
);

    logic [7:0]  dev_type;
    logic [15:0] dev_temp;
    logic [3:0]  done_bits;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_type  <= '0;
            dev_temp  <= '0;
            done_bits <= '0;
            cfg       <= '0;
        end else begin
            if (type_load) begin
                dev_type <= DEV_TYPE;
            end
            if (conf_load) begin
                dev_temp <= DEV_TEMP;
                cfg      <= '{freq_samp: cmd.freq_samp,
                              filt_up:   cmd.filt_up,
                              filt_low:  cmd.filt_low};
            end
            done_bits <= done_bits | done_mark;       // Sticky until reset
        end
    end

    assign stat = '{dev_temp:  dev_temp,
                    dev_type:  dev_type,
                    done_bits: done_bits,
                    rsvd:      4'h0};

endmodule

// File: adc_chan_fifo.sv
`timescale 1ns/1ps

module adc_chan_fifo
    import adc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_en,
    input  sample_t din,
    output logic    full,
    input  logic    rd_en,
    output sample_t dout,
    output logic    valid
);

    sample_t            mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == FIFO_CW'(FIFO_DEPTH));
    assign valid = (count != '0);
    assign dout  = mem[rd_ptr];                       // Head always shown

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && valid;

    // ######################################
    // Storage
    // ######################################

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // ######################################
    // Pointers and occupancy
    // ######################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;              // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer must honour full
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full);

endmodule

// File: adc_pattern_gen.sv
`timescale 1ns/1ps

module adc_pattern_gen
    import adc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 conv_run,
    input  adc_cfg_t             cfg,
    input  logic [NUM_CH-1:0]    full,
    output logic [NUM_CH-1:0]    wr_en,
    output sample_t [NUM_CH-1:0] wr_data,
    output logic                 conv_end
);

    logic              run_q;
    logic              busy;
    logic [3:0]        div;
    logic [SCNT_W-1:0] cnt;
    logic              fire;
    sample_t           lo_lim;
    sample_t           hi_lim;

    // Write slot reached and every channel has room
    assign fire  = busy && (div == '0) && !(|full);
    assign wr_en = {NUM_CH{fire}};

    assign lo_lim = {cfg.filt_low, 4'h0};
    assign hi_lim = {cfg.filt_up, 4'hF};

    // ######################################
    // Per-channel ramp with clipping
    // ######################################

    for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
        sample_t raw;

        assign raw = CH_BIAS[k*SAMPLE_W +: SAMPLE_W] + sample_t'(cnt);
        assign wr_data[k] = (raw < lo_lim) ? lo_lim :
                            (raw > hi_lim) ? hi_lim : raw;
    end

    // ######################################
    // Pacing and sample count
    // ######################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q    <= 1'b0;
            busy     <= 1'b0;
            div      <= '0;
            cnt      <= '0;
            conv_end <= 1'b0;
        end else begin
            run_q    <= conv_run;
            conv_end <= 1'b0;
            if (conv_run && !run_q) begin             // New run
                busy <= 1'b1;
                div  <= cfg.freq_samp;
                cnt  <= '0;
            end else if (busy) begin
                if (div != '0) begin
                    div <= div - 1'b1;
                end else if (fire) begin
                    div <= cfg.freq_samp;
                    cnt <= cnt + 1'b1;
                    if (cnt == SCNT_W'(NUM_SAMPLES - 1)) begin
                        busy     <= 1'b0;
                        conv_end <= 1'b1;
                    end
                end
                // Stall at a zero divider keeps the sample for a retry
            end
        end
    end

    // A stalled write retries with the same sample
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (busy && (div == '0) && (|full)) |=> $stable(wr_data));

endmodule

// File: adc_ctrl.sv
`timescale 1ns/1ps

module adc_ctrl
    import adc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fs_init,
    input  logic       fs_type,
    input  logic       fs_conf,
    input  logic       fs_conv,
    output logic       fd_init,
    output logic       fd_type,
    output logic       fd_conf,
    output logic       fd_conv,
    input  logic       conv_end,
    output logic       conv_run,
    output logic       type_load,
    output logic       conf_load,
    output logic [3:0] done_mark
);

    ctrl_state_t       state;
    ctrl_state_t       next_state;
    logic [WORK_W-1:0] num;

    // ######################################
    // State register and next state
    // ######################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                if (fs_init) begin                    // Fixed priority
                    next_state = INIT_IDLE;
                end else if (fs_type) begin
                    next_state = TYPE_IDLE;
                end else if (fs_conf) begin
                    next_state = CONF_IDLE;
                end else if (fs_conv) begin
                    next_state = CONV_IDLE;
                end
            end
            INIT_IDLE: next_state = INIT_WORK;
            INIT_WORK: begin
                if (num >= WORK_W'(NUM_INIT - 1)) next_state = INIT_DONE;
            end
            INIT_DONE: begin
                if (!fs_init) next_state = WAIT;
            end
            TYPE_IDLE: next_state = TYPE_WORK;
            TYPE_WORK: begin
                if (num >= WORK_W'(NUM_TYPE - 1)) next_state = TYPE_DONE;
            end
            TYPE_DONE: begin
                if (!fs_type) next_state = WAIT;
            end
            CONF_IDLE: next_state = CONF_WORK;
            CONF_WORK: begin
                if (num >= WORK_W'(NUM_CONF - 1)) next_state = CONF_DONE;
            end
            CONF_DONE: begin
                if (!fs_conf) next_state = WAIT;
            end
            CONV_IDLE: next_state = CONV_WORK;
            CONV_WORK: begin
                if (conv_end) next_state = CONV_DONE;   // Generator finished
            end
            CONV_DONE: begin
                if (!fs_conv) next_state = WAIT;
            end
            default: next_state = IDLE;
        endcase
    end

    // Counts only in the fixed-length work states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (state inside {INIT_WORK, TYPE_WORK, CONF_WORK}) begin
            num <= num + 1'b1;
        end else begin
            num <= '0;
        end
    end

    // ######################################
    // Outputs
    // ######################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_init <= 1'b0;
            fd_type <= 1'b0;
            fd_conf <= 1'b0;
            fd_conv <= 1'b0;
        end else begin
            fd_init <= (state == INIT_DONE);          // Registered, one cycle after entry
            fd_type <= (state == TYPE_DONE);
            fd_conf <= (state == CONF_DONE);
            fd_conv <= (state == CONV_DONE);
        end
    end

    assign type_load = (state == TYPE_IDLE);
    assign conf_load = (state == CONF_IDLE);
    assign conv_run  = (state == CONV_WORK);

    // Pulse on the edge that enters each DONE state
    assign done_mark[0] = (state == INIT_WORK) && (next_state == INIT_DONE);
    assign done_mark[1] = (state == TYPE_WORK) && (next_state == TYPE_DONE);
    assign done_mark[2] = (state == CONF_WORK) && (next_state == CONF_DONE);
    assign done_mark[3] = (state == CONV_WORK) && conv_end;

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, WAIT, INIT_IDLE, INIT_WORK, INIT_DONE, TYPE_IDLE, TYPE_WORK,
                      TYPE_DONE, CONF_IDLE, CONF_WORK, CONF_DONE, CONV_IDLE, CONV_WORK,
                      CONV_DONE});

    // The generator may only finish a run this FSM started
    a_end_in_work: assert property (@(posedge clk) disable iff (rst)
        conv_end |-> (state == CONV_WORK));

endmodule

// File: adc_pkg.sv
package adc_pkg;

    // ######################################
    // Sizes and counts
    // ######################################

    localparam int NUM_CH      = 8;
    localparam int SAMPLE_W    = 8;
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW     = FIFO_AW + 1;         // Occupancy needs one more bit

    localparam int WORK_W      = 12;                  // Work counter width
    localparam int NUM_INIT    = 16;
    localparam int NUM_TYPE    = 16;
    localparam int NUM_CONF    = 32;

    localparam int NUM_SAMPLES = 16;                  // Writes per channel and conversion
    localparam int SCNT_W      = $clog2(NUM_SAMPLES);

    // Byte k is the ramp start of channel k
    localparam logic [63:0] CH_BIAS  = 64'h0F0D_0B09_0705_0301;
    localparam logic [7:0]  DEV_TYPE = 8'hFF;
    localparam logic [15:0] DEV_TEMP = 16'h73F4;

    // ######################################
    // Controller states
    // ######################################

    typedef enum logic [7:0] {
        IDLE      = 8'h00,
        WAIT      = 8'h01,
        INIT_IDLE = 8'h10,
        INIT_WORK = 8'h11,
        INIT_DONE = 8'h12,
        TYPE_IDLE = 8'h20,
        TYPE_WORK = 8'h21,
        TYPE_DONE = 8'h22,
        CONF_IDLE = 8'h30,
        CONF_WORK = 8'h31,
        CONF_DONE = 8'h32,
        CONV_IDLE = 8'h40,
        CONV_WORK = 8'h41,
        CONV_DONE = 8'h42
    } ctrl_state_t;

    // ######################################
    // Command, status and sample types
    // ######################################

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic [7:0]  rsvd_hi;
        logic [3:0]  freq_samp;   // Pacing divider reload
        logic [3:0]  filt_up;     // Upper clip nibble
        logic [3:0]  filt_low;    // Lower clip nibble
        logic [11:0] rsvd_lo;
    } adc_cmd_t;

    typedef struct packed {
        logic [15:0] dev_temp;
        logic [7:0]  dev_type;
        logic [3:0]  done_bits;   // conv, conf, type, init
        logic [3:0]  rsvd;
    } adc_stat_t;

    typedef struct packed {
        logic [3:0] freq_samp;
        logic [3:0] filt_up;
        logic [3:0] filt_low;
    } adc_cfg_t;

endpackage
